/* include/predict_config.svh */
`ifndef PREDICT_CONFIG_SVH
`define PREDICT_CONFIG_SVH

// Image edges.
`define PRED_IN_DIM  52
`define PRED_SC_DIM  28

// Layer sizes.
`define PRED_HID_LEN 64
`define PRED_OUT_LEN 10

// Weight rule ((n*MUL_N + i*MUL_I + L*MUL_L) mod MOD) - OFS.
`define PRED_W_MUL_N 37
`define PRED_W_MUL_I 11
`define PRED_W_MUL_L 5
`define PRED_W_MOD   15
`define PRED_W_OFS   7

`endif

/* hdl/predict_pkg.sv */
`include "predict_config.svh"

package predict_pkg;

    // Pixel (r, c) sits at bit r * edge + c.
    typedef logic [`PRED_IN_DIM*`PRED_IN_DIM-1:0] img_t;
    typedef logic [`PRED_SC_DIM*`PRED_SC_DIM-1:0] scaled_t;

    typedef logic signed [15:0] act_t;    // Hidden activation.
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [31:0] acc_t;    // Accumulator and class score.

    // Element k belongs to neuron k.
    typedef struct packed {
        act_t [`PRED_HID_LEN-1:0] act;
    } hidden_t;

    typedef struct packed {
        acc_t [`PRED_OUT_LEN-1:0] score;
    } scores_t;

endpackage

/* hdl/image_scale.sv */
`timescale 1ns/1ns
`include "predict_config.svh"

module image_scale (
    input  predict_pkg::img_t    img,
    output predict_pkg::scaled_t scaled_img
);

    localparam int IN  = `PRED_IN_DIM;
    localparam int SC  = `PRED_SC_DIM;

    for (genvar r = 0; r < SC; r++) begin : g_row
        // Nearest-neighbour source row and its lower neighbour.
        localparam int R0 = r * IN / SC;
        localparam int R1 = (R0 + 1 > IN - 1) ? IN - 1 : R0 + 1;

        for (genvar c = 0; c < SC; c++) begin : g_col
            localparam int C0 = c * IN / SC;
            localparam int C1 = (C0 + 1 > IN - 1) ? IN - 1 : C0 + 1;

            // 2x2 OR keeps one-pixel strokes alive.
            assign scaled_img[r*SC + c] = img[R0*IN + C0] | img[R0*IN + C1] |
                                          img[R1*IN + C0] | img[R1*IN + C1];
        end
    end

endmodule

/* hdl/weight_rom.sv */
`timescale 1ns/1ns
`include "predict_config.svh"

module weight_rom #(
    parameter int LAYER_ID = 0
) (
    input  logic                clk,
    input  logic [5:0]          neuron,
    input  logic [9:0]          index,
    output predict_pkg::weight_t weight
);
    import predict_pkg::*;

    logic [15:0] rule_sum;
    logic [3:0]  rule_mod;

    // Largest sum 63*37 + 1023*11 + 5 fits well inside 16 bits.
    always_comb begin
        rule_sum = 16'(neuron) * 16'(`PRED_W_MUL_N)
                 + 16'(index) * 16'(`PRED_W_MUL_I)
                 + 16'(LAYER_ID * `PRED_W_MUL_L);
        rule_mod = 4'(rule_sum % 16'(`PRED_W_MOD));
    end

    always_ff @(posedge clk) begin
        weight <= $signed({4'b0000, rule_mod}) - weight_t'(`PRED_W_OFS); // Range -7..7.
    end

endmodule

/* hdl/dense_layer.sv */
`timescale 1ns/1ns

module dense_layer #(
    parameter type in_t     = logic,
    parameter int  IN_LEN   = 784,
    parameter int  OUT_LEN  = 64,
    parameter int  LAYER_ID = 0,
    parameter bit  RELU     = 1'b1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  in_t [IN_LEN-1:0]                 layer_in,
    output predict_pkg::acc_t [OUT_LEN-1:0]  layer_out,
    output logic                             finish
);
    import predict_pkg::*;

    // Steps 0..IN_LEN-1 issue addresses and the last step writes the sum.
    localparam logic [9:0] LAST_STEP   = 10'(IN_LEN + 1);
    localparam logic [5:0] LAST_NEURON = 6'(OUT_LEN - 1);
    localparam acc_t       ACT_MAX     = acc_t'(2 ** ($bits(act_t) - 1) - 1);

    logic              busy;
    logic [5:0]        neuron;
    logic [9:0]        index;
    logic [9:0]        index_d;   // Index matching the registered weight.
    logic              valid_d;
    in_t [IN_LEN-1:0]  in_reg;
    in_t               in_sel;
    weight_t           weight;
    acc_t              term;
    acc_t              acc;
    acc_t              result;

    weight_rom #(
        .LAYER_ID(LAYER_ID)
    ) u_rom (
        .clk   (clk),
        .neuron(neuron),
        .index (index),
        .weight(weight)
    );

    assign in_sel = in_reg[index_d];

    if ($bits(in_t) == 1) begin : g_gate
        assign term = in_sel ? acc_t'(weight) : '0; // Pixel only enables the weight.
    end else begin : g_mul
        assign term = acc_t'($signed(in_sel)) * acc_t'(weight);
    end

    always_comb begin
        result = acc;
        if (RELU) begin
            if (acc < 0) begin
                result = '0;
            end else if (acc > ACT_MAX) begin
                result = ACT_MAX;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            neuron  <= '0;
            index   <= '0;
            valid_d <= 1'b0;
            finish  <= 1'b0;
        end else begin
            finish  <= 1'b0;
            valid_d <= busy && (index < 10'(IN_LEN));
            if (start && !busy) begin
                busy   <= 1'b1;
                neuron <= '0;
                index  <= '0;
            end else if (busy) begin
                if (index == LAST_STEP) begin
                    index <= '0;
                    if (neuron == LAST_NEURON) begin
                        busy   <= 1'b0;
                        finish <= 1'b1;  // Same edge as the last write.
                    end else begin
                        neuron <= neuron + 6'd1;
                    end
                end else begin
                    index <= index + 10'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        index_d <= index;
        if (start && !busy) begin
            in_reg <= layer_in;
            acc    <= '0;
        end else if (busy && index == LAST_STEP) begin
            layer_out[neuron] <= result;
            acc               <= '0;
        end else if (valid_d) begin
            acc <= acc + term;
        end
    end

endmodule

/* hdl/argmax_onehot.sv */
`timescale 1ns/1ns
`include "predict_config.svh"

module argmax_onehot (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  predict_pkg::scores_t      scores,
    output logic [`PRED_OUT_LEN-1:0]  onehot,
    output logic                      done
);
    import predict_pkg::*;

    localparam logic [3:0] LAST = 4'(`PRED_OUT_LEN - 1);

    logic       busy;
    logic [3:0] cnt;
    acc_t       cur;
    acc_t       best_val;
    logic [3:0] best_idx;
    logic       take;
    logic [3:0] next_idx;

    assign cur      = scores.score[cnt];
    assign take     = (cnt == '0) || (cur > best_val); // Ties keep the lower index.
    assign next_idx = take ? cnt : best_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            onehot <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 4'd1;
                if (cnt == LAST) begin
                    busy   <= 1'b0;
                    done   <= 1'b1;
                    onehot <= {{(`PRED_OUT_LEN-1){1'b0}}, 1'b1} << next_idx;
                end
            end
        end
    end

    // Running maximum.
    always_ff @(posedge clk) begin
        if (busy) begin
            best_val <= take ? cur : best_val;
            best_idx <= next_idx;
        end
    end

endmodule

/* hdl/predict.sv */
`timescale 1ns/1ns
`include "predict_config.svh"

module predict (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [`PRED_IN_DIM*`PRED_IN_DIM-1:0]   track_input,
    output logic [`PRED_OUT_LEN-1:0]               onehot_output,
    output logic                                   finish
);
    import predict_pkg::*;

    typedef enum logic [1:0] {
        S_WAIT,
        S_DENSE0,
        S_DENSE1,
        S_SELECT
    } state_t;

    state_t                   state;
    img_t                     img_reg;
    scaled_t                  scaled;
    logic                     start_dense_0;
    logic                     finish_dense_0;
    logic                     finish_dense_1;
    acc_t [`PRED_HID_LEN-1:0] dense0_out;
    hidden_t                  hidden;
    scores_t                  scores;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_WAIT;
            start_dense_0 <= 1'b0;
        end else begin
            start_dense_0 <= 1'b0;
            case (state)
                S_WAIT: begin
                    if (start) begin
                        state         <= S_DENSE0;
                        start_dense_0 <= 1'b1;
                    end
                end
                S_DENSE0: if (finish_dense_0) state <= S_DENSE1;
                S_DENSE1: if (finish_dense_1) state <= S_SELECT;
                S_SELECT: if (finish) state <= S_WAIT;
                default:  state <= S_WAIT;
            endcase
        end
    end

    // Image is held for the whole run.
    always_ff @(posedge clk) begin
        if (state == S_WAIT && start) begin
            img_reg <= track_input;
        end
    end

    image_scale u_scale (
        .img       (img_reg),
        .scaled_img(scaled)
    );

    dense_layer #(
        .in_t    (logic),
        .IN_LEN  (`PRED_SC_DIM*`PRED_SC_DIM),
        .OUT_LEN (`PRED_HID_LEN),
        .LAYER_ID(0),
        .RELU    (1'b1)
    ) u_dense_0 (
        .clk      (clk),
        .rst      (rst),
        .start    (start_dense_0),
        .layer_in (scaled),
        .layer_out(dense0_out),
        .finish   (finish_dense_0)
    );

    // Layer 0 saturates to the act_t range so narrowing is lossless.
    always_comb begin
        for (int k = 0; k < `PRED_HID_LEN; k++) begin
            hidden.act[k] = act_t'(dense0_out[k]);
        end
    end

    dense_layer #(
        .in_t    (act_t),
        .IN_LEN  (`PRED_HID_LEN),
        .OUT_LEN (`PRED_OUT_LEN),
        .LAYER_ID(1),
        .RELU    (1'b0)
    ) u_dense_1 (
        .clk      (clk),
        .rst      (rst),
        .start    (finish_dense_0),
        .layer_in (hidden.act),
        .layer_out(scores.score),
        .finish   (finish_dense_1)
    );

    argmax_onehot u_argmax (
        .clk   (clk),
        .rst   (rst),
        .start (finish_dense_1),
        .scores(scores),
        .onehot(onehot_output),
        .done  (finish)
    );

endmodule

/* test/predict_tb.sv */
`timescale 1ns/1ns
`include "predict_config.svh"

module predict_tb;
    import predict_pkg::*;

    localparam int CYCLE_LIMIT = 400000; // Six runs of about 52k cycles plus margin.
    localparam int PIXELS      = `PRED_IN_DIM * `PRED_IN_DIM;

    logic                      clk;
    logic                      rst;
    logic                      start;
    logic [PIXELS-1:0]         track_input;
    logic [`PRED_OUT_LEN-1:0]  onehot_output;
    logic                      finish;

    int                        cycles;
    int                        finish_count;
    bit                        expect_finish;
    logic [`PRED_OUT_LEN-1:0]  prev_onehot;

    predict i_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .track_input  (track_input),
        .onehot_output(onehot_output),
        .finish       (finish)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error: %s expected %0h actual %0h", name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first mismatch.");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first failure.");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure("Timeout: the run did not complete within the cycle limit.");
        end
    end

    // Output monitor, sampled away from the active edge.
    always @(negedge clk) begin
        if (rst) begin
            prev_onehot = '0;
        end else begin
            if (finish) finish_count++;
            assert (!finish || expect_finish)
                else report_failure("finish pulsed without an accepted start.");
            assert (finish || onehot_output === prev_onehot)
                else report_mismatch("onehot_hold", prev_onehot, onehot_output);
            if (finish_count > 0) begin
                assert ($onehot(onehot_output))
                    else report_failure("onehot_output does not have exactly one bit set.");
            end
            prev_onehot = onehot_output;
        end
    end

    function automatic int weight_of(input int layer, input int n, input int i);
        return ((n * `PRED_W_MUL_N + i * `PRED_W_MUL_I + layer * `PRED_W_MUL_L)
                % `PRED_W_MOD) - `PRED_W_OFS;
    endfunction

    function automatic scaled_t scale_image(input img_t img);
        scaled_t s;
        int r0, r1, c0, c1;
        for (int r = 0; r < `PRED_SC_DIM; r++) begin
            r0 = r * `PRED_IN_DIM / `PRED_SC_DIM;
            r1 = (r0 + 1 > `PRED_IN_DIM - 1) ? `PRED_IN_DIM - 1 : r0 + 1;
            for (int c = 0; c < `PRED_SC_DIM; c++) begin
                c0 = c * `PRED_IN_DIM / `PRED_SC_DIM;
                c1 = (c0 + 1 > `PRED_IN_DIM - 1) ? `PRED_IN_DIM - 1 : c0 + 1;
                s[r*`PRED_SC_DIM + c] = img[r0*`PRED_IN_DIM + c0] | img[r0*`PRED_IN_DIM + c1]
                                      | img[r1*`PRED_IN_DIM + c0] | img[r1*`PRED_IN_DIM + c1];
            end
        end
        return s;
    endfunction

    function automatic longint relu_sat(input longint x);
        if (x < 0) return 0;
        if (x > 32767) return 32767;
        return x;
    endfunction

    // Full reference through scaling, both layers and the first maximum.
    function automatic logic [`PRED_OUT_LEN-1:0] predict_ref(input img_t img);
        scaled_t s;
        longint  hid[`PRED_HID_LEN];
        longint  score[`PRED_OUT_LEN];
        longint  sum;
        int      best;
        s = scale_image(img);
        for (int n = 0; n < `PRED_HID_LEN; n++) begin
            sum = 0;
            for (int i = 0; i < `PRED_SC_DIM * `PRED_SC_DIM; i++) begin
                if (s[i]) sum += weight_of(0, n, i);
            end
            hid[n] = relu_sat(sum);
        end
        for (int n = 0; n < `PRED_OUT_LEN; n++) begin
            sum = 0;
            for (int i = 0; i < `PRED_HID_LEN; i++) begin
                sum += hid[i] * weight_of(1, n, i);
            end
            score[n] = sum;
        end
        best = 0;
        for (int k = 1; k < `PRED_OUT_LEN; k++) begin
            if (score[k] > score[best]) best = k;
        end
        return 10'b1 << best;
    endfunction

    function automatic img_t random_image();
        img_t img;
        int   density;
        density = $urandom_range(5, 60); // Percent of set pixels.
        for (int k = 0; k < PIXELS; k++) begin
            img[k] = ($urandom_range(0, 99) < density);
        end
        return img;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
    endtask

    task automatic wait_finish();
        while (finish !== 1'b1) step_cycle();
        step_cycle();
        expect_finish = 1'b0;
    endtask

    task automatic run_and_check(input string name, input img_t img);
        logic [`PRED_OUT_LEN-1:0] exp;
        exp           = predict_ref(img);
        track_input   = img;
        expect_finish = 1'b1;
        pulse_start();
        wait_finish();
        assert (onehot_output === exp) else report_mismatch(name, exp, onehot_output);
    endtask

    initial begin
        img_t                     img_a;
        logic [`PRED_OUT_LEN-1:0] exp;
        int                       count_before;

        void'($urandom(32'ha71ce205));
        rst           = 1'b1;
        clk           = 1'b0;
        start         = 1'b0;
        track_input   = '0;
        cycles        = 0;
        finish_count  = 0;
        expect_finish = 1'b0;
        prev_onehot   = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        step_cycle();
        assert (finish === 1'b0) else report_mismatch("reset_finish", 0, finish);
        assert (onehot_output === '0) else report_mismatch("reset_onehot", 0, onehot_output);
        repeat (10) step_cycle();

        run_and_check("zero_image", '0);
        assert (onehot_output === 10'b1) else report_mismatch("zero_class", 1, onehot_output);

        for (int t = 0; t < 3; t++) begin
            run_and_check($sformatf("random_image_%0d", t), random_image());
        end

        // Extra starts with new images during dense 0 and dense 1.
        img_a         = random_image();
        exp           = predict_ref(img_a);
        count_before  = finish_count;
        track_input   = img_a;
        expect_finish = 1'b1;
        pulse_start();
        repeat (10) step_cycle();
        track_input = random_image();
        pulse_start();
        repeat (30000) step_cycle();
        track_input = random_image();
        pulse_start();
        repeat (20340) step_cycle();
        pulse_start();
        wait_finish();
        repeat (20) step_cycle();
        assert (finish_count == count_before + 1)
            else report_mismatch("ignored_start_count", count_before + 1, finish_count);
        assert (onehot_output === exp) else report_mismatch("ignored_start", exp, onehot_output);

        // Input changes right after capture.
        img_a         = random_image();
        exp           = predict_ref(img_a);
        track_input   = img_a;
        expect_finish = 1'b1;
        pulse_start();
        track_input = ~img_a;
        wait_finish();
        assert (onehot_output === exp) else report_mismatch("input_change", exp, onehot_output);

        repeat (10) step_cycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hdl/predict_pkg.sv
hdl/image_scale.sv
hdl/weight_rom.sv
hdl/dense_layer.sv
hdl/argmax_onehot.sv
hdl/predict.sv
test/predict_tb.sv

/* Bender.yml */
package:
  name: predict

sources:
  - include_dirs:
      - include
    files:
      - hdl/predict_pkg.sv
      - hdl/image_scale.sv
      - hdl/weight_rom.sv
      - hdl/dense_layer.sv
      - hdl/argmax_onehot.sv
      - hdl/predict.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/predict_tb.sv
